/* logic/board_pkg.sv */
// Board control shared definitions

package board_pkg;

    // ------------------------------
    // bus and field widths
    // ------------------------------
    localparam int ADDR_W   = 16;           // host address
    localparam int DATA_W   = 32;           // register data
    localparam int NUM_AXES = 4;            // amplifier channels on the board
    localparam int BLK_W    = 4;            // block select, addr[15:12]
    localparam int OFS_W    = 4;            // register offset, addr[3:0]
    localparam int WDOG_W   = 16;           // watchdog period and count
    localparam int TEMP_W   = 16;           // temperature sensor reading
    localparam int BID_W    = 4;            // rotary switch board id

    // only block 0 lives in this design
    localparam logic [BLK_W-1:0] BLK_MAIN = 4'h0;

    // firmware version word, read at REG_VERSION
    localparam logic [DATA_W-1:0] FW_VERSION = 32'h514C_4107;

    // ------------------------------
    // register offsets in block 0
    // ------------------------------
    typedef enum logic [OFS_W-1:0] {
        REG_STATUS  = 4'd0,                 // masked control, packed status
        REG_TIMEOUT = 4'd3,                 // watchdog period in ticks
        REG_VERSION = 4'd4,                 // read only
        REG_TEMPSNS = 4'd5,                 // read only
        REG_DIGIN   = 4'd10                 // read only, packed inputs
    } reg_addr_e;

    // ------------------------------
    // internal register bus opcode
    // ------------------------------
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,                    // nothing on the bus
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } bus_op_e;

    // arbiter FSM
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,                    // bus empty
        ARB_BUSY = 2'd1,                    // one transaction on the bus
        ARB_HOLD = 2'd2                     // winner on bus, loser parked
    } arb_state_e;

endpackage

/* logic/host_arbiter.sv */
// Two-port host bus arbiter

`timescale 1ns/1ps

module host_arbiter (
    input  logic                            sysclk,
    input  logic                            reset,
    // host port 0, firewire
    input  logic                            fw_req,
    input  board_pkg::bus_op_e              fw_op,
    input  logic [board_pkg::ADDR_W-1:0]    fw_addr,
    input  logic [board_pkg::DATA_W-1:0]    fw_wdata,
    output logic [board_pkg::DATA_W-1:0]    fw_rdata,
    output logic                            fw_done,
    // host port 1, ethernet
    input  logic                            eth_req,
    input  board_pkg::bus_op_e              eth_op,
    input  logic [board_pkg::ADDR_W-1:0]    eth_addr,
    input  logic [board_pkg::DATA_W-1:0]    eth_wdata,
    output logic [board_pkg::DATA_W-1:0]    eth_rdata,
    output logic                            eth_done,
    // shared register bus
    output board_pkg::bus_op_e              bus_op,
    output logic [board_pkg::OFS_W-1:0]     bus_addr,
    output logic [board_pkg::DATA_W-1:0]    bus_wdata,
    input  logic [board_pkg::DATA_W-1:0]    bus_rdata
);
    import board_pkg::*;

    arb_state_e         state;
    logic               own_eth;            // owner of the transaction on the bus
    logic               last_eth;           // last arbitration winner
    logic               win_eth;            // this cycle's grant goes to port 1
    bus_op_e            fw_bop;             // opcodes after the block check
    bus_op_e            eth_bop;
    bus_op_e            hold_op;            // parked loser
    logic [OFS_W-1:0]   hold_addr;
    logic [DATA_W-1:0]  hold_wdata;

    // foreign block still completes, just never touches the registers
    function automatic bus_op_e map_op(input bus_op_e op, input logic [ADDR_W-1:0] addr);
        if (addr[ADDR_W-1 -: BLK_W] == BLK_MAIN)
            return op;
        return OP_IDLE;
    endfunction

    assign fw_bop  = map_op(fw_op, fw_addr);
    assign eth_bop = map_op(eth_op, eth_addr);

    // port not granted last wins a tie
    assign win_eth = eth_req && (!fw_req || !last_eth);

    // ------------------------------
    // FSM and done pulses
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            state    <= ARB_IDLE;
            bus_op   <= OP_IDLE;
            own_eth  <= 1'b0;
            last_eth <= 1'b1;                   // so port 0 wins the first tie
            fw_done  <= 1'b0;
            eth_done <= 1'b0;
        end else begin
            // regs answer one cycle after the bus, done goes with it
            fw_done  <= (state != ARB_IDLE) && !own_eth;
            eth_done <= (state != ARB_IDLE) && own_eth;
            case (state)
                ARB_HOLD: begin
                    bus_op  <= hold_op;         // release the loser
                    own_eth <= !own_eth;
                    state   <= ARB_BUSY;
                end
                default: begin
                    if (fw_req || eth_req) begin
                        bus_op   <= win_eth ? eth_bop : fw_bop;
                        own_eth  <= win_eth;
                        last_eth <= win_eth;
                        state    <= (fw_req && eth_req) ? ARB_HOLD : ARB_BUSY;
                    end else begin
                        bus_op <= OP_IDLE;
                        state  <= ARB_IDLE;
                    end
                end
            endcase
        end
    end

    // bus payload and parked request
    always_ff @(posedge sysclk) begin
        if (state == ARB_HOLD) begin
            bus_addr  <= hold_addr;
            bus_wdata <= hold_wdata;
        end else if (fw_req || eth_req) begin
            bus_addr   <= win_eth ? eth_addr[OFS_W-1:0] : fw_addr[OFS_W-1:0];
            bus_wdata  <= win_eth ? eth_wdata : fw_wdata;
            hold_op    <= win_eth ? fw_bop : eth_bop;   // only used on a tie
            hold_addr  <= win_eth ? fw_addr[OFS_W-1:0] : eth_addr[OFS_W-1:0];
            hold_wdata <= win_eth ? fw_wdata : eth_wdata;
        end
    end

    // read data steered to the owner only
    assign fw_rdata  = fw_done  ? bus_rdata : '0;
    assign eth_rdata = eth_done ? bus_rdata : '0;

endmodule

/* logic/board_regs.sv */
// Board general register file

`timescale 1ns/1ps

module board_regs (
    input  logic                                sysclk,
    input  logic                                reset,
    // register bus
    input  board_pkg::bus_op_e                  bus_op,
    input  logic [board_pkg::OFS_W-1:0]         bus_addr,
    input  logic [board_pkg::DATA_W-1:0]        bus_wdata,
    output logic [board_pkg::DATA_W-1:0]        bus_rdata,
    // board status inputs
    input  logic [board_pkg::NUM_AXES-1:0]      fault,
    input  logic                                relay,          // relay contact state
    input  logic                                mv_good,        // motor voltage good
    input  logic                                v_fault,
    input  logic [board_pkg::BID_W-1:0]         board_id,
    input  logic [board_pkg::TEMP_W-1:0]        temp_sense,
    input  logic [board_pkg::NUM_AXES-1:0]      enc_a,
    input  logic [board_pkg::NUM_AXES-1:0]      enc_b,
    input  logic [board_pkg::NUM_AXES-1:0]      enc_i,
    input  logic [board_pkg::NUM_AXES-1:0]      neg_limit,
    input  logic [board_pkg::NUM_AXES-1:0]      pos_limit,
    input  logic [board_pkg::NUM_AXES-1:0]      home,
    input  logic [board_pkg::NUM_AXES-1:0]      safety_amp_disable,
    // from the guard
    input  logic                                wdog_timeout,
    input  logic                                guard_disable,
    // control outputs
    output logic [board_pkg::NUM_AXES-1:0]      reg_disable,
    output logic                                pwr_enable,
    output logic                                relay_on,
    output logic                                eth1394,        // 0 firewire, 1 eth-1394
    output logic [board_pkg::WDOG_W-1:0]        wdog_period,
    output logic                                host_write
);
    import board_pkg::*;

    logic [DATA_W-1:0] status_word;
    logic [DATA_W-1:0] digin_word;

    // any accepted write kicks the watchdog
    assign host_write = (bus_op == OP_WRITE);

    // ------------------------------
    // read words
    // ------------------------------
    assign status_word = {
        4'(NUM_AXES), board_id,                     // byte 3
        wdog_timeout, eth1394, 1'b0, guard_disable, // byte 2 high nibble
        mv_good, pwr_enable, ~relay, relay_on,
        4'd0, fault,                                // byte 1
        safety_amp_disable, ~reg_disable            // byte 0, 1 means enabled
    };

    assign digin_word = {
        v_fault, 3'd0,
        enc_a, enc_b, enc_i,
        4'd0,                                       // no digital outputs here
        neg_limit, pos_limit, home
    };

    // ------------------------------
    // control registers
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            reg_disable <= '1;                      // everything off at start
            pwr_enable  <= 1'b0;
            relay_on    <= 1'b0;
            eth1394     <= 1'b0;
            wdog_period <= '0;                      // watchdog off
        end else if (bus_op == OP_WRITE) begin
            case (bus_addr)
                REG_STATUS: begin
                    // bits 11:8 qualify the enables in 3:0
                    for (int i = 0; i < NUM_AXES; i++) begin
                        reg_disable[i] <= ~pwr_enable |
                                          (bus_wdata[8+i] ? ~bus_wdata[i] : reg_disable[i]);
                    end
                    if (bus_wdata[17])
                        relay_on <= bus_wdata[16];  // safety relay
                    if (bus_wdata[19])
                        pwr_enable <= bus_wdata[18];
                    if (bus_wdata[23])
                        eth1394 <= bus_wdata[22];   // link mode
                end
                REG_TIMEOUT: wdog_period <= bus_wdata[WDOG_W-1:0];
                default: ;                          // read-only or unmapped
            endcase
        end else begin
            // safety chain and watchdog latch the disables
            if ((safety_amp_disable != '0) || wdog_timeout)
                reg_disable <= reg_disable | safety_amp_disable | {NUM_AXES{wdog_timeout}};
        end
    end

    // ------------------------------
    // registered read mux
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (bus_op == OP_READ) begin
            case (bus_addr)
                REG_STATUS:  bus_rdata <= status_word;
                REG_TIMEOUT: bus_rdata <= {{(DATA_W-WDOG_W){1'b0}}, wdog_period};
                REG_VERSION: bus_rdata <= FW_VERSION;
                REG_TEMPSNS: bus_rdata <= {{(DATA_W-TEMP_W){1'b0}}, temp_sense};
                REG_DIGIN:   bus_rdata <= digin_word;
                default:     bus_rdata <= '0;       // unknown offset
            endcase
        end else begin
            bus_rdata <= '0;                        // writes and foreign blocks read zero
        end
    end

endmodule

/* logic/amp_guard.sv */
// Amplifier watchdog and settle guard

`timescale 1ns/1ps

module amp_guard #(
    parameter int TICK_DIV        = 256,        // sysclk cycles per tick
    parameter int MV_SETTLE_TICKS = 7680        // hold-off after mv_good
) (
    input  logic                            sysclk,
    input  logic                            reset,
    input  logic                            host_write,     // any register write
    input  logic [board_pkg::WDOG_W-1:0]    wdog_period,    // 0 turns it off
    input  logic                            mv_good,
    output logic                            wdog_timeout,
    output logic                            guard_disable
);
    import board_pkg::*;

    localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam int SET_W = $clog2(MV_SETTLE_TICKS + 1);

    logic [PRE_W-1:0]   pre_cnt;
    logic               tick;
    logic [WDOG_W-1:0]  wdog_count;
    logic [SET_W-1:0]   settle_cnt;

    // ------------------------------
    // tick prescaler
    // ------------------------------
    assign tick = (pre_cnt == PRE_W'(TICK_DIV - 1));

    always_ff @(posedge sysclk) begin
        if (!reset)
            pre_cnt <= '0;
        else if (tick)
            pre_cnt <= '0;
        else
            pre_cnt <= pre_cnt + 1'b1;
    end

    // ------------------------------
    // host watchdog
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else if (host_write) begin
            wdog_count   <= '0;                 // host is alive
            wdog_timeout <= 1'b0;
        end else if (wdog_period != '0) begin
            if (wdog_count >= wdog_period)
                wdog_timeout <= 1'b1;           // stays until next write
            else if (tick)
                wdog_count <= wdog_count + 1'b1;
        end
    end

    // ------------------------------
    // motor voltage settle
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            settle_cnt    <= '0;
            guard_disable <= 1'b1;
        end else if (!mv_good) begin
            settle_cnt    <= '0;                // restart on every dropout
            guard_disable <= 1'b1;
        end else if (settle_cnt < SET_W'(MV_SETTLE_TICKS)) begin
            guard_disable <= 1'b1;
            if (tick)
                settle_cnt <= settle_cnt + 1'b1;
        end else begin
            guard_disable <= 1'b0;              // settled, release amps
        end
    end

endmodule

/* logic/board_ctrl_top.sv */
// Board control top level

`timescale 1ns/1ps

module board_ctrl_top #(
    parameter int TICK_DIV        = 256,
    parameter int MV_SETTLE_TICKS = 7680
) (
    input  logic                                sysclk,
    input  logic                                reset,
    // firewire host port
    input  logic                                fw_req,
    input  board_pkg::bus_op_e                  fw_op,
    input  logic [board_pkg::ADDR_W-1:0]        fw_addr,
    input  logic [board_pkg::DATA_W-1:0]        fw_wdata,
    output logic [board_pkg::DATA_W-1:0]        fw_rdata,
    output logic                                fw_done,
    // ethernet host port
    input  logic                                eth_req,
    input  board_pkg::bus_op_e                  eth_op,
    input  logic [board_pkg::ADDR_W-1:0]        eth_addr,
    input  logic [board_pkg::DATA_W-1:0]        eth_wdata,
    output logic [board_pkg::DATA_W-1:0]        eth_rdata,
    output logic                                eth_done,
    // board signals
    input  logic [board_pkg::NUM_AXES-1:0]      fault,
    input  logic                                relay,
    input  logic                                mv_good,
    input  logic                                v_fault,
    input  logic [board_pkg::BID_W-1:0]         board_id,
    input  logic [board_pkg::TEMP_W-1:0]        temp_sense,
    input  logic [board_pkg::NUM_AXES-1:0]      enc_a,
    input  logic [board_pkg::NUM_AXES-1:0]      enc_b,
    input  logic [board_pkg::NUM_AXES-1:0]      enc_i,
    input  logic [board_pkg::NUM_AXES-1:0]      neg_limit,
    input  logic [board_pkg::NUM_AXES-1:0]      pos_limit,
    input  logic [board_pkg::NUM_AXES-1:0]      home,
    input  logic [board_pkg::NUM_AXES-1:0]      safety_amp_disable,
    // outputs to the board
    output logic [board_pkg::NUM_AXES-1:0]      amp_disable,
    output logic                                pwr_enable,
    output logic                                relay_on,
    output logic                                eth1394
);
    import board_pkg::*;

    bus_op_e            bus_op;
    logic [OFS_W-1:0]   bus_addr;
    logic [DATA_W-1:0]  bus_wdata;
    logic [DATA_W-1:0]  bus_rdata;
    logic [NUM_AXES-1:0] reg_disable;
    logic [WDOG_W-1:0]  wdog_period;
    logic               host_write;
    logic               wdog_timeout;
    logic               guard_disable;      // high until motor voltage settles

    // ------------------------------
    // host ports onto one bus
    // ------------------------------
    host_arbiter u_host_arbiter (
        .sysclk, .reset,
        .fw_req, .fw_op, .fw_addr, .fw_wdata, .fw_rdata, .fw_done,
        .eth_req, .eth_op, .eth_addr, .eth_wdata, .eth_rdata, .eth_done,
        .bus_op, .bus_addr, .bus_wdata, .bus_rdata
    );

    board_regs u_board_regs (
        .sysclk, .reset,
        .bus_op, .bus_addr, .bus_wdata, .bus_rdata,
        .fault, .relay, .mv_good, .v_fault, .board_id, .temp_sense,
        .enc_a, .enc_b, .enc_i, .neg_limit, .pos_limit, .home,
        .safety_amp_disable, .wdog_timeout, .guard_disable,
        .reg_disable, .pwr_enable, .relay_on, .eth1394,
        .wdog_period, .host_write
    );

    amp_guard #(
        .TICK_DIV       (TICK_DIV),
        .MV_SETTLE_TICKS(MV_SETTLE_TICKS)
    ) u_amp_guard (
        .sysclk, .reset,
        .host_write, .wdog_period, .mv_good,
        .wdog_timeout, .guard_disable
    );

    // guard overrides the register mask on every axis
    assign amp_disable = reg_disable | {NUM_AXES{guard_disable}};

endmodule

/* sim/board_ctrl_chk.sv */
// Arbiter timing checks

`timescale 1ns/1ps

module board_ctrl_chk (
    input  logic                    sysclk,
    input  logic                    reset,
    input  logic                    fw_req,
    input  logic                    eth_req,
    input  logic                    fw_done,
    input  logic                    eth_done,
    input  board_pkg::arb_state_e   state
);
    import board_pkg::*;

    // ------------------------------
    // done pulses never overlap
    // ------------------------------
    a_done_excl: assert property (@(posedge sysclk) disable iff (!reset)
        !(fw_done && eth_done))
        else $error("done pulse on both host ports in one cycle");

    // lone request on an idle bus completes two edges later
    a_fw_lone: assert property (@(posedge sysclk) disable iff (!reset)
        (fw_req && !eth_req && state == ARB_IDLE) |-> ##2 fw_done)
        else $error("port 0 lone request not done two cycles later");

    a_eth_lone: assert property (@(posedge sysclk) disable iff (!reset)
        (eth_req && !fw_req && state == ARB_IDLE) |-> ##2 eth_done)
        else $error("port 1 lone request not done two cycles later");

endmodule

bind host_arbiter board_ctrl_chk u_board_ctrl_chk (
    .sysclk  (sysclk),
    .reset   (reset),
    .fw_req  (fw_req),
    .eth_req (eth_req),
    .fw_done (fw_done),
    .eth_done(eth_done),
    .state   (state)
);

/* sim/board_ctrl_tb.sv */
// Board control testbench

`timescale 1ns/1ps

module board_ctrl_tb;
    import board_pkg::*;

    localparam int TICK_DIV        = 4;
    localparam int MV_SETTLE_TICKS = 20;
    localparam int CLK_PERIOD      = 40;
    localparam int WD_TICKS        = 5;     // watchdog period under test
    localparam int RUN_CYCLES      = 10 + 600 + (MV_SETTLE_TICKS + 2) * TICK_DIV
                                     + 6 * (WD_TICKS + 1) * TICK_DIV + 200;

    logic               sysclk;
    logic               reset;
    logic               fw_req;
    bus_op_e            fw_op;
    logic [ADDR_W-1:0]  fw_addr;
    logic [DATA_W-1:0]  fw_wdata;
    logic [DATA_W-1:0]  fw_rdata;
    logic               fw_done;
    logic               eth_req;
    bus_op_e            eth_op;
    logic [ADDR_W-1:0]  eth_addr;
    logic [DATA_W-1:0]  eth_wdata;
    logic [DATA_W-1:0]  eth_rdata;
    logic               eth_done;
    logic [NUM_AXES-1:0] fault, enc_a, enc_b, enc_i, neg_limit, pos_limit, home;
    logic [NUM_AXES-1:0] safety_amp_disable, amp_disable;
    logic               relay, mv_good, v_fault, pwr_enable, relay_on, eth1394;
    logic [BID_W-1:0]   board_id;
    logic [TEMP_W-1:0]  temp_sense;

    // reference model state
    logic [NUM_AXES-1:0] m_dis;
    logic               m_pwr, m_relay_on, m_eth, m_wdog, m_guard;
    logic [WDOG_W-1:0]  m_period;
    logic               rr_last_eth;    // last port granted
    logic [DATA_W-1:0]  fw_q[$];        // expected words per port
    logic [DATA_W-1:0]  eth_q[$];
    logic [DATA_W-1:0]  fw_exp, eth_exp, w;
    int                 cycle, fw_done_cyc, eth_done_cyc, seed, n;

    board_ctrl_top #(
        .TICK_DIV       (TICK_DIV),
        .MV_SETTLE_TICKS(MV_SETTLE_TICKS)
    ) u_board_ctrl_top (.*);

    initial sysclk = 1'b0;
    always #(CLK_PERIOD / 2) sysclk = ~sysclk;

    initial cycle = 0;
    always @(posedge sysclk) cycle <= cycle + 1;

    // ------------------------------
    // failure reporting
    // ------------------------------
    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic fail_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
        stop_run();
    endtask

    task automatic fail_text(input string msg);
        $display("%0t ns: %s", $time, msg);
        stop_run();
    endtask

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic logic [DATA_W-1:0] expect_read(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] r;
        r = '0;
        if (addr[15:12] == 4'h0) begin          // other blocks read zero
            case (addr[3:0])
                REG_STATUS:  r = {4'd4, board_id, m_wdog, m_eth, 1'b0, m_guard,
                                  mv_good, m_pwr, ~relay, m_relay_on, 4'd0, fault,
                                  safety_amp_disable, ~m_dis};
                REG_TIMEOUT: r = {16'd0, m_period};
                REG_VERSION: r = FW_VERSION;
                REG_TEMPSNS: r = {16'd0, temp_sense};
                REG_DIGIN:   r = {v_fault, 3'd0, enc_a, enc_b, enc_i, 4'd0,
                                  neg_limit, pos_limit, home};
                default:     r = '0;
            endcase
        end
        return r;
    endfunction

    function automatic void apply_write(input logic [ADDR_W-1:0] addr,
                                        input logic [DATA_W-1:0] d);
        if (addr[15:12] != 4'h0)
            return;                             // foreign block, no effect
        m_wdog = 1'b0;                          // any write kicks the watchdog
        if (addr[3:0] == REG_STATUS) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                if (!m_pwr)
                    m_dis[i] = 1'b1;            // power was off before this write
                else if (d[8+i])
                    m_dis[i] = !d[i];           // enable bit, disable is its inverse
            end
            if (d[17]) m_relay_on = d[16];
            if (d[19]) m_pwr = d[18];
            if (d[23]) m_eth = d[22];
        end else if (addr[3:0] == REG_TIMEOUT) begin
            m_period = d[WDOG_W-1:0];
        end
    endfunction

    function automatic logic [ADDR_W-1:0] blk0(input logic [3:0] ofs);
        return {12'h000, ofs};
    endfunction

    // ------------------------------
    // host port tasks
    // ------------------------------
    task automatic drive_port(input bit to_eth, input bus_op_e op,
                              input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] e;
        e = (op == OP_READ) ? expect_read(addr) : '0;
        if (op == OP_WRITE)
            apply_write(addr, d);
        if (to_eth) begin
            eth_op    = op;
            eth_addr  = addr;
            eth_wdata = d;
            eth_req   = 1'b1;
            eth_q.push_back(e);
        end else begin
            fw_op    = op;
            fw_addr  = addr;
            fw_wdata = d;
            fw_req   = 1'b1;
            fw_q.push_back(e);
        end
    endtask

    task automatic wait_done();
        int k;
        k = 0;
        while (fw_q.size() != 0 || eth_q.size() != 0) begin
            @(posedge sysclk);
            k++;
            if (k > 8)
                fail_text("host request never got its done pulse");
        end
    endtask

    task automatic request(input bit to_eth, input bus_op_e op,
                           input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] d);
        @(posedge sysclk);
        #2;
        drive_port(to_eth, op, addr, d);
        rr_last_eth = to_eth;
        @(posedge sysclk);
        #2;
        fw_req  = 1'b0;                         // single-cycle strobe
        eth_req = 1'b0;
        wait_done();
    endtask

    // both ports read in the same cycle
    task automatic request_pair(input logic [ADDR_W-1:0] fa, input logic [ADDR_W-1:0] ea);
        bit eth_wins;
        @(posedge sysclk);
        #2;
        drive_port(1'b0, OP_READ, fa, '0);
        drive_port(1'b1, OP_READ, ea, '0);
        eth_wins = !rr_last_eth;                // port not served last wins
        @(posedge sysclk);
        #2;
        fw_req  = 1'b0;
        eth_req = 1'b0;
        wait_done();
        if (eth_wins) begin
            assert (fw_done_cyc == eth_done_cyc + 1)
                else fail_text("port 0 lost the tie but did not finish one cycle later");
        end else begin
            assert (eth_done_cyc == fw_done_cyc + 1)
                else fail_text("port 1 lost the tie but did not finish one cycle later");
        end
        rr_last_eth = eth_wins;
    endtask

    task automatic check_amp(input logic [NUM_AXES-1:0] e);
        assert (amp_disable === e)
            else fail_value("amp_disable", {28'd0, amp_disable}, {28'd0, e});
    endtask

    // power, relay and link mode pins
    task automatic check_ctrl();
        assert (pwr_enable === m_pwr)
            else fail_value("pwr_enable", {31'd0, pwr_enable}, {31'd0, m_pwr});
        assert (relay_on === m_relay_on)
            else fail_value("relay_on", {31'd0, relay_on}, {31'd0, m_relay_on});
        assert (eth1394 === m_eth)
            else fail_value("eth1394", {31'd0, eth1394}, {31'd0, m_eth});
    endtask

    // ------------------------------
    // compare process
    // ------------------------------
    always @(negedge sysclk) begin
        if (reset && fw_done) begin
            assert (fw_q.size() > 0) else fail_text("done on port 0 with nothing pending");
            fw_exp = fw_q.pop_front();
            assert (fw_rdata === fw_exp) else fail_value("fw_rdata", fw_rdata, fw_exp);
            fw_done_cyc = cycle;
        end
        if (reset && eth_done) begin
            assert (eth_q.size() > 0) else fail_text("done on port 1 with nothing pending");
            eth_exp = eth_q.pop_front();
            assert (eth_rdata === eth_exp) else fail_value("eth_rdata", eth_rdata, eth_exp);
            eth_done_cyc = cycle;
        end
    end

    // run limit from the summed test length
    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        fail_text("simulation timeout, tests did not finish in time");
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        seed = 32'h6f4b;
        reset = 1'b0;
        fw_req = 1'b0;
        fw_op = OP_IDLE;
        fw_addr = '0;
        fw_wdata = '0;
        eth_req = 1'b0;
        eth_op = OP_IDLE;
        eth_addr = '0;
        eth_wdata = '0;
        fault = '0;
        relay = 1'b0;
        mv_good = 1'b0;
        v_fault = 1'b0;
        board_id = 4'h9;
        temp_sense = '0;
        enc_a = '0;
        enc_b = '0;
        enc_i = '0;
        neg_limit = '0;
        pos_limit = '0;
        home = '0;
        safety_amp_disable = '0;
        m_dis = '1;
        m_pwr = 1'b0;
        m_relay_on = 1'b0;
        m_eth = 1'b0;
        m_wdog = 1'b0;
        m_guard = 1'b1;
        m_period = '0;
        rr_last_eth = 1'b1;                     // port 0 first after reset
        repeat (10) @(posedge sysclk);
        #2 reset = 1'b1;

        // reset values
        check_amp(4'hF);
        check_ctrl();
        assert (!fw_done && !eth_done) else fail_text("done pulse high after reset");
        request(1'b0, OP_READ, blk0(REG_STATUS), '0);
        request(1'b1, OP_READ, blk0(REG_VERSION), '0);
        request(1'b0, OP_READ, blk0(REG_TIMEOUT), '0);

        // masked writes, power kept off
        for (int k = 0; k < 4; k++) begin
            w = $random(seed);
            w[19] = 1'b0;
            request(1'b0, OP_WRITE, blk0(REG_STATUS), w);
            request(1'b1, OP_READ, blk0(REG_STATUS), '0);
            check_amp(4'hF);
            check_ctrl();
        end
        request(1'b0, OP_WRITE, blk0(REG_STATUS), 32'h000C_0000);   // power on
        for (int k = 0; k < 6; k++) begin
            w = $random(seed);
            w[19:18] = 2'b11;                   // keep power on
            request(k[0], OP_WRITE, blk0(REG_STATUS), w);
            request(!k[0], OP_READ, blk0(REG_STATUS), '0);
            check_amp(4'hF);                    // guard still holds
            check_ctrl();
        end

        // input words, unknown offsets, foreign block
        @(posedge sysclk);
        #2;
        fault = 4'($random(seed));
        relay = 1'($random(seed));
        v_fault = 1'b1;
        board_id = 4'($random(seed));
        temp_sense = 16'($random(seed));
        enc_a = 4'($random(seed));
        enc_b = 4'($random(seed));
        enc_i = 4'($random(seed));
        neg_limit = 4'($random(seed));
        pos_limit = 4'($random(seed));
        home = 4'($random(seed));
        request(1'b0, OP_READ, blk0(REG_DIGIN), '0);
        request(1'b1, OP_READ, blk0(REG_TEMPSNS), '0);
        request(1'b0, OP_READ, blk0(REG_STATUS), '0);
        request(1'b1, OP_READ, blk0(4'd7), '0);
        request(1'b0, OP_READ, blk0(4'd15), '0);
        request(1'b1, OP_READ, 16'h1004, '0);
        request(1'b0, OP_WRITE, 16'h1003, 32'h0000_00FF);
        request(1'b1, OP_READ, blk0(REG_TIMEOUT), '0);

        // ties alternate between ports
        request_pair(blk0(REG_VERSION), blk0(REG_DIGIN));
        request_pair(blk0(REG_STATUS), blk0(REG_TEMPSNS));
        request_pair(blk0(REG_DIGIN), 16'h2000);
        request_pair(blk0(REG_TIMEOUT), blk0(REG_VERSION));

        // motor voltage settle
        request(1'b0, OP_WRITE, blk0(REG_STATUS), 32'h000C_0F05);  // axes 0, 2 on
        @(posedge sysclk);
        #2 mv_good = 1'b1;
        n = 0;
        while (amp_disable === 4'hF) begin
            @(negedge sysclk);
            n++;
            if (n > (MV_SETTLE_TICKS + 1) * TICK_DIV + 4)
                fail_text("amplifiers still held after the settle time");
        end
        assert (n >= (MV_SETTLE_TICKS - 1) * TICK_DIV)
            else fail_text("amplifiers released before the settle time");
        m_guard = 1'b0;
        check_amp(m_dis);
        check_ctrl();
        request(1'b1, OP_READ, blk0(REG_STATUS), '0);

        // watchdog expiry
        request(1'b0, OP_WRITE, blk0(REG_TIMEOUT), 32'(WD_TICKS));
        n = 0;
        while (amp_disable !== 4'hF) begin
            @(negedge sysclk);
            n++;
            if (n > (WD_TICKS + 1) * TICK_DIV + 4)
                fail_text("watchdog did not disable the amplifiers in time");
        end
        assert (n >= (WD_TICKS - 1) * TICK_DIV)
            else fail_text("watchdog disabled the amplifiers before the period ran out");
        m_wdog = 1'b1;
        m_dis  = '1;                            // timeout latches all disables
        request(1'b0, OP_READ, blk0(REG_STATUS), '0);

        // writes before expiry keep it quiet
        request(1'b1, OP_WRITE, blk0(REG_STATUS), 32'h000C_0F05);
        for (int k = 0; k < 3; k++) begin
            repeat ((WD_TICKS - 2) * TICK_DIV) @(posedge sysclk);
            request(1'b0, OP_WRITE, blk0(REG_STATUS), 32'h000C_0F05);
        end
        request(1'b1, OP_READ, blk0(REG_STATUS), '0);
        check_amp(m_dis);
        request(1'b0, OP_WRITE, blk0(REG_TIMEOUT), '0);             // watchdog off

        // motor voltage dropout
        @(posedge sysclk);
        #2 mv_good = 1'b0;
        m_guard = 1'b1;
        repeat (2) @(negedge sysclk);
        check_amp(4'hF);
        check_ctrl();
        request(1'b1, OP_READ, blk0(REG_STATUS), '0);

        $display("TB PASSED");
        $finish;
    end

endmodule

/* verilog.f */
logic/board_pkg.sv
logic/host_arbiter.sv
logic/board_regs.sv
logic/amp_guard.sv
logic/board_ctrl_top.sv
sim/board_ctrl_chk.sv
sim/board_ctrl_tb.sv

/* Makefile */
# Verilator build and run for the board control testbench

VERILATOR ?= verilator
TOP       ?= board_ctrl_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIMFLAGS  ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIMFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS)

clean:
	rm -rf $(BUILD_DIR)
